//--- hdl/lane_pkg.sv
// FIFO_DEPTH must be a power of two and NUM_ENGINES must equal 2**ENGINE_ID_W
package lane_pkg;

    // --------------------
    // Lane sizing
    // --------------------
    localparam int NUM_ENGINES      = 4;
    localparam int ENGINE_ID_W      = 2;
    localparam int ADDR_W           = 32;
    localparam int DATA_W           = 32;

    // Queue depth shared by the request and response paths
    localparam int FIFO_DEPTH       = 4;
    // One slot kept free for a packet already in flight
    localparam int FIFO_ALMOST_FULL = 3;
    localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W       = $clog2(FIFO_DEPTH + 1);

    // --------------------
    // Vector types
    // --------------------
    // Engine that issued a request and receives its response
    typedef logic [ENGINE_ID_W-1:0] engine_id_t;
    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    // One bit per engine for grants, ready and done levels
    typedef logic [NUM_ENGINES-1:0] engine_mask_t;
    typedef logic [FIFO_PTR_W-1:0]  fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0]  fifo_cnt_t;

    // --------------------
    // Memory packet
    // --------------------
    // Same layout for requests and responses, 67 bits
    typedef struct packed {
        logic       valid;
        engine_id_t id;
        addr_t      address;
        data_t      data;
    } mem_packet_t;

    // Lane run state
    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_RUN  = 2'd1,
        LANE_DONE = 2'd2
    } lane_state_t;

endpackage : lane_pkg

//--- hdl/lane_fifo.sv
// Writes to a full queue and reads from an empty one are dropped, and rd_data_o is combinational
`timescale 1ns/1ps

module lane_fifo (
    input  logic                  ap_clk,
    input  logic                  areset_lane_template,
    input  logic                  wr_en_i,
    input  lane_pkg::mem_packet_t wr_data_i,
    input  logic                  rd_en_i,
    output lane_pkg::mem_packet_t rd_data_o,
    output logic                  empty_o,
    output logic                  almost_full_o
);
    import lane_pkg::*;

    mem_packet_t mem [FIFO_DEPTH-1:0];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_cnt_t   count;
    logic        full;
    logic        push;
    logic        pop;

    // --------------------
    // Occupancy flags
    // --------------------
    assign full          = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign empty_o       = (count == '0);
    assign almost_full_o = (count >= fifo_cnt_t'(FIFO_ALMOST_FULL));

    // Guard against overflow and underflow
    assign push = wr_en_i & ~full;
    assign pop  = rd_en_i & ~empty_o;

    // Storage array
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own since depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue, valid only while something is stored
    always_comb begin
        rd_data_o       = mem[rd_ptr];
        rd_data_o.valid = ~empty_o;
    end

endmodule : lane_fifo

//--- hdl/lane_request_arbiter.sv
// Requesters must hold valid until granted, and mem_req_ready_i arrives one cycle late via lane_top
`timescale 1ns/1ps

module lane_request_arbiter (
    input  logic                   ap_clk,
    input  logic                   areset_lane_template,
    input  lane_pkg::mem_packet_t  req_i [lane_pkg::NUM_ENGINES-1:0],
    output lane_pkg::engine_mask_t grant_o,
    output lane_pkg::mem_packet_t  mem_req_o,
    input  logic                   mem_req_ready_i,
    output logic                   empty_o
);
    import lane_pkg::*;

    engine_mask_t req_valid;
    engine_mask_t grant_next;
    engine_mask_t grant_d;
    engine_id_t   rr_ptr;
    engine_id_t   grant_idx;
    logic         grant_any;
    mem_packet_t  fifo_wr_data;
    mem_packet_t  fifo_head;
    logic         fifo_almost_full;

    // --------------------
    // Request masking
    // --------------------
    // A granted engine stays masked for two cycles
    // Its old request is still visible through the input register
    always_comb begin
        for (int i = 0; i < NUM_ENGINES; i++) begin
            req_valid[i] = req_i[i].valid & ~grant_o[i] & ~grant_d[i];
        end
    end

    // --------------------
    // Round-robin pick
    // --------------------
    // First valid requester at or after the pointer
    always_comb begin
        engine_id_t idx;
        grant_next = '0;
        grant_idx  = '0;
        grant_any  = 1'b0;
        for (int off = 0; off < NUM_ENGINES; off++) begin
            idx = rr_ptr + engine_id_t'(off);
            if (!grant_any && req_valid[idx] && !fifo_almost_full) begin
                grant_any       = 1'b1;
                grant_idx       = idx;
                grant_next[idx] = 1'b1;
            end
        end
    end

    // Queue entry carries the grant index as its id
    always_comb begin
        fifo_wr_data    = req_i[grant_idx];
        fifo_wr_data.id = grant_idx;
    end

    // Grant register and pointer update
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            grant_o <= '0;
            grant_d <= '0;
            rr_ptr  <= '0;
        end else begin
            grant_o <= grant_next;
            grant_d <= grant_o;
            if (grant_any) begin
                rr_ptr <= grant_idx + 1'b1;
            end
        end
    end

    // --------------------
    // Queue toward memory
    // --------------------
    lane_fifo u_req_fifo (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .wr_en_i              (grant_any),
        .wr_data_i            (fifo_wr_data),
        .rd_en_i              (mem_req_ready_i),
        .rd_data_o            (fifo_head),
        .empty_o              (empty_o),
        .almost_full_o        (fifo_almost_full)
    );

    // Each valid cycle is one packet popped from the head
    always_comb begin
        mem_req_o       = fifo_head;
        mem_req_o.valid = fifo_head.valid & mem_req_ready_i;
    end

endmodule : lane_request_arbiter

//--- hdl/lane_response_router.sv
// In-order delivery, so a stalled engine blocks all later responses behind it
`timescale 1ns/1ps

module lane_response_router (
    input  logic                   ap_clk,
    input  logic                   areset_lane_template,
    input  lane_pkg::mem_packet_t  rsp_i,
    output logic                   rsp_ready_o,
    output lane_pkg::mem_packet_t  engine_rsp_o [lane_pkg::NUM_ENGINES-1:0],
    input  lane_pkg::engine_mask_t engine_ready_i,
    output logic                   empty_o
);
    import lane_pkg::*;

    mem_packet_t  fifo_head;
    logic         fifo_almost_full;
    engine_mask_t head_sel;
    logic         head_fire;

    // --------------------
    // Response queue
    // --------------------
    lane_fifo u_rsp_fifo (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .wr_en_i              (rsp_i.valid),
        .wr_data_i            (rsp_i),
        .rd_en_i              (head_fire),
        .rd_data_o            (fifo_head),
        .empty_o              (empty_o),
        .almost_full_o        (fifo_almost_full)
    );

    // --------------------
    // Head decode
    // --------------------
    // One-hot target from the head id
    always_comb begin
        head_sel               = '0;
        head_sel[fifo_head.id] = fifo_head.valid;
    end

    // Pop only when the target engine is ready
    assign head_fire = |(head_sel & engine_ready_i);

    // Same payload on every slot, valid only on the target
    always_comb begin
        for (int i = 0; i < NUM_ENGINES; i++) begin
            engine_rsp_o[i]       = fifo_head;
            engine_rsp_o[i].valid = head_sel[i] & engine_ready_i[i];
        end
    end

    // --------------------
    // Back-pressure
    // --------------------
    // Low out of reset, then follows queue headroom
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            rsp_ready_o <= 1'b0;
        end else begin
            rsp_ready_o <= ~fifo_almost_full;
        end
    end

endmodule : lane_response_router

//--- hdl/lane_status.sv
// engine_done_i levels are used as is, and done_o holds until the next start_i or reset
`timescale 1ns/1ps

module lane_status (
    input  logic                   ap_clk,
    input  logic                   areset_lane_template,
    input  logic                   start_i,
    input  lane_pkg::engine_mask_t engine_done_i,
    input  logic                   req_empty_i,
    input  logic                   rsp_empty_i,
    output logic                   done_o
);
    import lane_pkg::*;

    lane_state_t state;
    lane_state_t state_next;
    logic        lane_quiet;

    // All engines finished and nothing left in either queue
    assign lane_quiet = (&engine_done_i) & req_empty_i & rsp_empty_i;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            LANE_IDLE: begin
                if (start_i) begin
                    state_next = LANE_RUN;
                end
            end
            LANE_RUN: begin
                if (lane_quiet) begin
                    state_next = LANE_DONE;
                end
            end
            LANE_DONE: begin
                // New descriptor restarts the run
                if (start_i) begin
                    state_next = LANE_RUN;
                end
            end
            default: state_next = LANE_IDLE;
        endcase
    end

    // State and done registers
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            state  <= LANE_IDLE;
            done_o <= 1'b0;
        end else begin
            state  <= state_next;
            done_o <= (state_next == LANE_DONE);
        end
    end

endmodule : lane_status

//--- hdl/lane_top.sv
// All inputs but engine_done_i are registered, so ready levels act one cycle late
`timescale 1ns/1ps

module lane_top (
    input  logic                   ap_clk,
    input  logic                   areset_i,
    input  logic                   start_i,
    input  lane_pkg::mem_packet_t  engine_req_i [lane_pkg::NUM_ENGINES-1:0],
    output lane_pkg::engine_mask_t engine_req_grant_o,
    output lane_pkg::mem_packet_t  engine_rsp_o [lane_pkg::NUM_ENGINES-1:0],
    input  lane_pkg::engine_mask_t engine_rsp_ready_i,
    input  lane_pkg::engine_mask_t engine_done_i,
    output lane_pkg::mem_packet_t  mem_req_o,
    input  logic                   mem_req_ready_i,
    input  lane_pkg::mem_packet_t  mem_rsp_i,
    output logic                   mem_rsp_ready_o,
    output logic                   done_o
);
    import lane_pkg::*;

    logic         areset_lane_template;
    logic         start_q;
    mem_packet_t  engine_req_q [NUM_ENGINES-1:0];
    engine_mask_t engine_rsp_ready_q;
    logic         mem_req_ready_q;
    mem_packet_t  mem_rsp_q;
    logic         req_empty;
    logic         rsp_empty;

    // --------------------
    // Reset register
    // --------------------
    // Single lane-wide reset
    always_ff @(posedge ap_clk) begin
        areset_lane_template <= areset_i;
    end

    // --------------------
    // Input packets
    // --------------------
    // Payload passes freely, only the valid bits are cleared
    always_ff @(posedge ap_clk) begin
        for (int i = 0; i < NUM_ENGINES; i++) begin
            engine_req_q[i] <= engine_req_i[i];
        end
        mem_rsp_q <= mem_rsp_i;
        if (areset_lane_template) begin
            for (int i = 0; i < NUM_ENGINES; i++) begin
                engine_req_q[i].valid <= 1'b0;
            end
            mem_rsp_q.valid <= 1'b0;
        end
    end

    // Control level inputs
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            start_q            <= 1'b0;
            engine_rsp_ready_q <= '0;
            mem_req_ready_q    <= 1'b0;
        end else begin
            start_q            <= start_i;
            engine_rsp_ready_q <= engine_rsp_ready_i;
            mem_req_ready_q    <= mem_req_ready_i;
        end
    end

    // --------------------
    // Request path
    // --------------------
    lane_request_arbiter u_req_arbiter (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .req_i                (engine_req_q),
        .grant_o              (engine_req_grant_o),
        .mem_req_o            (mem_req_o),
        .mem_req_ready_i      (mem_req_ready_q),
        .empty_o              (req_empty)
    );

    // --------------------
    // Response path
    // --------------------
    lane_response_router u_rsp_router (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .rsp_i                (mem_rsp_q),
        .rsp_ready_o          (mem_rsp_ready_o),
        .engine_rsp_o         (engine_rsp_o),
        .engine_ready_i       (engine_rsp_ready_q),
        .empty_o              (rsp_empty)
    );

    // Done tracking over both queues
    lane_status u_status (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .start_i              (start_q),
        .engine_done_i        (engine_done_i),
        .req_empty_i          (req_empty),
        .rsp_empty_i          (rsp_empty),
        .done_o               (done_o)
    );

endmodule : lane_top

//--- dv/lane_tb.sv
// Engines drop a request the edge after their grant is seen, and the run stops at the first error
`timescale 1ns/1ps

module lane_tb;
    import lane_pkg::*;

    typedef enum logic [1:0] {PH_REQ, PH_RSP, PH_DONE} phase_t;
    typedef struct packed {
        phase_t       kind;
        engine_mask_t mask;
        addr_t        addr;
        data_t        data;
        engine_id_t   rsp_id;
        logic         stall;
    } entry_t;

    localparam int NUM_ENTRIES    = 10;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 50 * NUM_ENTRIES + RESET_CYCLES;

    logic         ap_clk;
    logic         areset_i;
    logic         start_i;
    mem_packet_t  engine_req_i [NUM_ENGINES-1:0];
    engine_mask_t engine_req_grant_o;
    mem_packet_t  engine_rsp_o [NUM_ENGINES-1:0];
    engine_mask_t engine_rsp_ready_i;
    engine_mask_t engine_done_i;
    mem_packet_t  mem_req_o;
    logic         mem_req_ready_i;
    mem_packet_t  mem_rsp_i;
    logic         mem_rsp_ready_o;
    logic         done_o;

    // Reference model state
    entry_t       table_q [NUM_ENTRIES];
    engine_id_t   rr_ptr;
    engine_id_t   pred_grant [$];
    mem_packet_t  exp_req_q [$];
    mem_packet_t  exp_rsp_q [$];
    engine_mask_t grant_seen;
    logic [31:0]  lfsr;
    logic         live;
    logic         started;
    int           errors;
    int           cycles;

    lane_top u_dut (.*);

    // --------------------
    // Clock and timeout
    // --------------------
    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic expect_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            errors++;
            $display("Error: %0t %s", $time, msg);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // --------------------
    // Output monitor
    // --------------------
    // Sampled at the falling edge where outputs are stable
    always @(negedge ap_clk) begin : monitor
        int nvalid;
        nvalid = 0;
        if (live) begin
            if (engine_req_grant_o != '0) begin
                expect_true($countones(engine_req_grant_o) == 1, "Grant is not one-hot");
                expect_true(pred_grant.size() > 0, "Grant with no request pending");
                expect_true(engine_req_grant_o[pred_grant[0]],
                    $sformatf("Grant %b, expected engine %0d", engine_req_grant_o,
                              pred_grant[0]));
                void'(pred_grant.pop_front());
                grant_seen = grant_seen | engine_req_grant_o;
            end
            if (mem_req_o.valid) begin
                expect_true(exp_req_q.size() > 0, "Unexpected packet on mem_req_o");
                expect_true(mem_req_o.id == exp_req_q[0].id && mem_req_o.data ==
                    exp_req_q[0].data && mem_req_o.address == exp_req_q[0].address,
                    $sformatf("mem_req_o id %0d addr %h, expected id %0d addr %h",
                              mem_req_o.id, mem_req_o.address, exp_req_q[0].id,
                              exp_req_q[0].address));
                void'(exp_req_q.pop_front());
            end
            for (int i = 0; i < NUM_ENGINES; i++) begin
                if (engine_rsp_o[i].valid) begin
                    nvalid++;
                    expect_true(exp_rsp_q.size() > 0, "Unexpected response delivered");
                    expect_true(exp_rsp_q[0].id == i && exp_rsp_q[0].data ==
                        engine_rsp_o[i].data && exp_rsp_q[0].address ==
                        engine_rsp_o[i].address,
                        $sformatf("Response on slot %0d, expected id %0d data %h", i,
                                  exp_rsp_q[0].id, exp_rsp_q[0].data));
                    void'(exp_rsp_q.pop_front());
                end
            end
            expect_true(nvalid <= 1, "More than one response slot valid");
            if (!started) begin
                expect_true(!done_o, "done_o high before any start");
            end
        end
    end

    // --------------------
    // Phase tasks
    // --------------------
    // Requests on the masked engines, order taken from the pointer model
    task automatic run_requests(input engine_mask_t mask, input addr_t addr,
                                input data_t data, input logic stall);
        logic [31:0]  r;
        int           stall_left;
        int           n_exp;
        engine_id_t   idx;
        engine_id_t   last;
        mem_packet_t  p;
        engine_mask_t pending;
        stall_left = 0;
        last       = rr_ptr;
        if (stall) begin
            draw_bits(4, r);
            stall_left = int'(r) + 6;
        end
        // Grants expected before the queue reaches almost-full
        n_exp = $countones(mask);
        if (n_exp > FIFO_ALMOST_FULL) begin
            n_exp = FIFO_ALMOST_FULL;
        end
        @(posedge ap_clk);
        for (int off = 0; off < NUM_ENGINES; off++) begin
            idx = rr_ptr + engine_id_t'(off);
            if (mask[idx]) begin
                draw_bits(32, r);
                p.valid   = 1'b1;
                // Engines leave id wrong, the arbiter fills it in
                p.id      = ~idx;
                p.address = addr + 32'(idx) * 4;
                p.data    = data ^ r;
                engine_req_i[idx] <= p;
                p.id      = idx;
                exp_req_q.push_back(p);
                pred_grant.push_back(idx);
                last = idx;
            end
        end
        if (mask != '0) begin
            rr_ptr = last + 1'b1;
        end
        if (stall) begin
            mem_req_ready_i <= 1'b0;
        end
        pending = mask;
        while (pending != '0 || exp_req_q.size() != 0) begin
            @(posedge ap_clk);
            for (int i = 0; i < NUM_ENGINES; i++) begin
                if (grant_seen[i]) begin
                    engine_req_i[i].valid <= 1'b0;
                    pending[i] = 1'b0;
                end
            end
            grant_seen = '0;
            if (stall_left > 0) begin
                stall_left--;
                if (stall_left == 0) begin
                    // Empty queue fills to the almost-full level while memory stalls
                    expect_true($countones(mask & ~pending) == n_exp,
                                "Grants did not stop at the almost-full level");
                    mem_req_ready_i <= 1'b1;
                end
            end
        end
    endtask

    task automatic send_response(input engine_id_t id, input data_t data);
        logic [31:0] r;
        mem_packet_t p;
        draw_bits(32, r);
        p = '{valid: 1'b1, id: id, address: r, data: data};
        do @(negedge ap_clk); while (!mem_rsp_ready_o);
        @(posedge ap_clk);
        mem_rsp_i <= p;
        exp_rsp_q.push_back(p);
    endtask

    // Two responses, the first one's target optionally stalled
    task automatic run_responses(input engine_id_t k, input data_t data, input logic stall);
        logic [31:0] r;
        @(posedge ap_clk);
        engine_rsp_ready_i <= stall ? ~(engine_mask_t'(1) << k) : '1;
        send_response(k, data);
        send_response(k + 1'b1, ~data);
        @(posedge ap_clk);
        mem_rsp_i.valid <= 1'b0;
        if (stall) begin
            draw_bits(4, r);
            repeat (int'(r) + 4) @(posedge ap_clk);
            expect_true(exp_rsp_q.size() == 2, "Response delivered past a stalled head");
            engine_rsp_ready_i <= '1;
        end
        while (exp_rsp_q.size() != 0) @(posedge ap_clk);
    endtask

    task automatic run_done(input engine_mask_t partial, input data_t data);
        int          n;
        engine_id_t  idx;
        mem_packet_t req;
        @(posedge ap_clk);
        engine_done_i <= partial;
        start_i       <= 1'b1;
        started = 1'b1;
        @(posedge ap_clk);
        start_i            <= 1'b0;
        engine_rsp_ready_i <= '0;
        repeat (5) @(negedge ap_clk);
        expect_true(!done_o, "done_o high while an engine is not done");
        // Request parked in the queue behind a memory stall
        @(posedge ap_clk);
        idx         = rr_ptr;
        req.valid   = 1'b1;
        req.id      = idx;
        req.address = 32'h0000_7000;
        req.data    = ~data;
        engine_req_i[idx] <= req;
        mem_req_ready_i   <= 1'b0;
        exp_req_q.push_back(req);
        pred_grant.push_back(idx);
        rr_ptr     = idx + 1'b1;
        grant_seen = '0;
        while (!grant_seen[idx]) @(posedge ap_clk);
        engine_req_i[idx].valid <= 1'b0;
        grant_seen = '0;
        engine_done_i <= '1;
        repeat (5) @(negedge ap_clk);
        expect_true(!done_o, "done_o high with a request outstanding");
        // Response parked in the queue keeps the lane busy
        send_response(2'd1, data);
        @(posedge ap_clk);
        mem_rsp_i.valid <= 1'b0;
        mem_req_ready_i <= 1'b1;
        while (exp_req_q.size() != 0) @(posedge ap_clk);
        repeat (5) @(negedge ap_clk);
        expect_true(!done_o, "done_o high with a response outstanding");
        @(posedge ap_clk);
        engine_rsp_ready_i <= '1;
        n = 0;
        do begin
            @(negedge ap_clk);
            n++;
        end while (!done_o && n < 20);
        expect_true(done_o, "done_o did not rise once the lane was idle");
        repeat (3) @(negedge ap_clk);
        expect_true(done_o, "done_o did not hold until the next start");
        @(posedge ap_clk);
        start_i       <= 1'b1;
        engine_done_i <= partial;
        @(posedge ap_clk);
        start_i <= 1'b0;
        repeat (4) @(negedge ap_clk);
        expect_true(!done_o, "done_o did not fall after a new start");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        areset_i           = 1'b1;
        start_i            = 1'b0;
        engine_rsp_ready_i = '1;
        engine_done_i      = '0;
        mem_req_ready_i    = 1'b1;
        mem_rsp_i          = '0;
        for (int i = 0; i < NUM_ENGINES; i++) begin
            engine_req_i[i] = '0;
        end
        rr_ptr     = '0;
        grant_seen = '0;
        lfsr       = 32'hc6cd;
        live       = 1'b0;
        started    = 1'b0;
        errors     = 0;
        cycles     = 0;
        // kind, mask, address, data, response id, stall
        table_q[0] = '{PH_REQ,  4'b1111, 32'h0000_1000, 32'ha5a5_0000, 2'd0, 1'b0};
        table_q[1] = '{PH_REQ,  4'b0010, 32'h0000_2000, 32'h1234_5678, 2'd0, 1'b0};
        table_q[2] = '{PH_REQ,  4'b1000, 32'h0000_3000, 32'h0bad_f00d, 2'd0, 1'b0};
        table_q[3] = '{PH_REQ,  4'b0110, 32'h0000_4000, 32'h5555_aaaa, 2'd0, 1'b0};
        table_q[4] = '{PH_REQ,  4'b1111, 32'h0000_5000, 32'hdead_beef, 2'd0, 1'b1};
        table_q[5] = '{PH_REQ,  4'b1011, 32'h0000_6000, 32'h0f0f_0f0f, 2'd0, 1'b1};
        table_q[6] = '{PH_RSP,  4'b0000, 32'h0,         32'hc0de_0002, 2'd2, 1'b0};
        table_q[7] = '{PH_RSP,  4'b0000, 32'h0,         32'hc0de_0001, 2'd1, 1'b1};
        table_q[8] = '{PH_RSP,  4'b0000, 32'h0,         32'hc0de_0003, 2'd3, 1'b1};
        table_q[9] = '{PH_DONE, 4'b0111, 32'h0,         32'hd0d0_0000, 2'd0, 1'b0};
        repeat (RESET_CYCLES) @(posedge ap_clk);
        areset_i <= 1'b0;
        @(posedge ap_clk);
        @(negedge ap_clk);
        // Lane reset just released, ready still low for this registered cycle
        expect_true(!mem_rsp_ready_o, "mem_rsp_ready_o high in the first cycle after reset");
        @(posedge ap_clk);
        @(negedge ap_clk);
        expect_true(engine_req_grant_o == '0 && !mem_req_o.valid && !done_o &&
                    mem_rsp_ready_o, "Outputs not idle after reset");
        live = 1'b1;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            case (table_q[e].kind)
                PH_REQ:  run_requests(table_q[e].mask, table_q[e].addr, table_q[e].data,
                                      table_q[e].stall);
                PH_RSP:  run_responses(table_q[e].rsp_id, table_q[e].data, table_q[e].stall);
                default: run_done(table_q[e].mask, table_q[e].data);
            endcase
        end
        repeat (2) @(negedge ap_clk);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : lane_tb

//--- compile.f
hdl/lane_pkg.sv
hdl/lane_fifo.sv
hdl/lane_request_arbiter.sv
hdl/lane_response_router.sv
hdl/lane_status.sv
hdl/lane_top.sv
dv/lane_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the lane testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module lane_tb -o lane_sim

# The simulator status is not trusted alone, the log decides
./obj_dir/lane_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
